//--- sources.f
logic/pinctl_pkg.sv
logic/ebi_bridge.sv
logic/pin_control.sv
logic/pinctl_top.sv
sim/pinctl_tb.sv

//--- Makefile
# Verilator build and run for the pin controller testbench
# usage: make compile | make run | make clean

VERILATOR ?= verilator
TOP       ?= pinctl_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/pinctl_tb.sv
// **************************************************
// testbench for the pin controller top level with
// bus writes and reads, register readback, square
// and PWM high time per period and the bus output
// enable
// **************************************************

`timescale 1ns/1ns
`default_nettype none

module pinctl_tb;

  localparam int aw    = pinctl_pkg::addr_w;
  localparam int dw    = pinctl_pkg::data_w;
  localparam int np    = pinctl_pkg::num_pins;
  localparam int idx_w = pinctl_pkg::reg_idx_w;
  // the tests take just under 3000 cycles
  localparam int cycle_limit = 20000;

  logic          sys_clk = 1'b0;
  logic          reset;
  logic          ebi_cs;
  logic          ebi_wr;
  logic          ebi_rd;
  logic [aw-1:0] ebi_addr;
  logic [dw-1:0] ebi_data_in;
  logic [dw-1:0] ebi_data_out;
  logic          ebi_data_oe;
  logic [np-1:0] pins;

  pinctl_pkg::pin_cfg_t model [np];

  int value_errors = 0;
  int oe_errors    = 0;
  int cycles       = 0;
  // output enable must stay low while set
  logic          oe_quiet   = 1'b0;
  // read waiting for the compare process
  logic          rd_pending = 1'b0;
  logic          rd_compare = 1'b0;
  logic [dw-1:0] rd_expect;
  logic [aw-1:0] rd_addr;

  pinctl_top dut0 (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .ebi_cs       (ebi_cs),
    .ebi_wr       (ebi_wr),
    .ebi_rd       (ebi_rd),
    .ebi_addr     (ebi_addr),
    .ebi_data_in  (ebi_data_in),
    .ebi_data_out (ebi_data_out),
    .ebi_data_oe  (ebi_data_oe),
    .pins         (pins)
  );

  always #4 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // outputs are compared at the falling edge where they are stable
  always @(negedge sys_clk) begin
    if (oe_quiet && ebi_data_oe !== 1'b0) begin
      oe_errors++;
      $display("FAILED at %0t: output enable high outside a read", $time);
    end
    if (rd_pending) begin
      if (ebi_data_oe !== 1'b1) begin
        oe_errors++;
        $display("FAILED at %0t: output enable low during read of 0x%0h", $time, rd_addr);
      end
      if (rd_compare && ebi_data_out !== rd_expect) begin
        value_errors++;
        $display("FAILED at %0t: read of 0x%0h returned 0x%0h, expected 0x%0h",
                 $time, rd_addr, ebi_data_out, rd_expect);
      end
      rd_pending = 1'b0;
    end
  end

  function automatic logic [aw-1:0] reg_addr(input int p, input logic [idx_w-1:0] r);
    return aw'(pinctl_pkg::pin_base + p * pinctl_pkg::words_per_pin + int'(r));
  endfunction

  // expected readback word with tick reading as zero
  function automatic logic [dw-1:0] expected_word(input logic [aw-1:0] addr);
    int off;
    int p;
    logic [dw-1:0] word;
    word = '0;
    off = int'(addr) - pinctl_pkg::pin_base;
    if (off >= 0 && off < np * pinctl_pkg::words_per_pin) begin
      p = off / pinctl_pkg::words_per_pin;
      case (off % pinctl_pkg::words_per_pin)
        int'(pinctl_pkg::reg_mode):   word = dw'(model[p].mode);
        int'(pinctl_pkg::reg_period): word = model[p].period;
        int'(pinctl_pkg::reg_duty):   word = model[p].duty;
        default:                      word = '0;
      endcase
    end
    return word;
  endfunction

  // high cycles in one whole period
  function automatic int high_per_period(input pinctl_pkg::pin_cfg_t cfg);
    int period;
    int duty;
    period = (cfg.period == '0) ? 1 : int'(cfg.period);
    duty = int'(cfg.duty);
    if (cfg.mode == pinctl_pkg::mode_square) begin
      return period / 2;
    end
    if (cfg.mode == pinctl_pkg::mode_pwm) begin
      return (duty < period) ? duty : period;
    end
    return 0;
  endfunction

  // strobe release takes about three cycles to reach the output enable
  task automatic bus_idle();
    repeat (3) @(posedge sys_clk);
    oe_quiet = 1'b1;
    repeat (3) @(posedge sys_clk);
  endtask

  task automatic bus_write(input logic [aw-1:0] addr, input logic [dw-1:0] data);
    @(posedge sys_clk);
    ebi_cs      <= 1'b0;
    ebi_wr      <= 1'b0;
    ebi_addr    <= addr;
    ebi_data_in <= data;
    repeat (6) @(posedge sys_clk);
    ebi_cs <= 1'b1;
    ebi_wr <= 1'b1;
    bus_idle();
  endtask

  task automatic bus_read(input logic [aw-1:0] addr, input logic [dw-1:0] expect_word,
                          input logic compare, output logic [dw-1:0] word);
    @(posedge sys_clk);
    oe_quiet = 1'b0;
    ebi_cs   <= 1'b0;
    ebi_rd   <= 1'b0;
    ebi_addr <= addr;
    repeat (6) @(posedge sys_clk);
    rd_addr    = addr;
    rd_expect  = expect_word;
    rd_compare = compare;
    rd_pending = 1'b1;
    @(negedge sys_clk);
    word = ebi_data_out;
    @(posedge sys_clk);
    ebi_cs <= 1'b1;
    ebi_rd <= 1'b1;
    bus_idle();
  endtask

  task automatic read_check(input logic [aw-1:0] addr, input logic [dw-1:0] expect_word);
    logic [dw-1:0] word;
    bus_read(addr, expect_word, 1'b1, word);
  endtask

  task automatic write_reg(input int p, input logic [idx_w-1:0] r, input logic [dw-1:0] data);
    bus_write(reg_addr(p, r), data);
    case (r)
      pinctl_pkg::reg_mode:   model[p].mode   = data[pinctl_pkg::mode_w-1:0];
      pinctl_pkg::reg_period: model[p].period = data;
      pinctl_pkg::reg_duty:   model[p].duty   = data;
      default: ;
    endcase
  endtask

  // four whole periods from a random start
  task automatic measure_pin(input int p);
    int period;
    int count;
    int expected;
    period = (model[p].period == '0) ? 1 : int'(model[p].period);
    expected = 4 * high_per_period(model[p]);
    count = 0;
    repeat ($urandom_range(7, 0)) @(posedge sys_clk);
    for (int i = 0; i < 4 * period; i++) begin
      @(negedge sys_clk);
      if (pins[p] === 1'b1) begin
        count++;
      end
    end
    if (count != expected) begin
      value_errors++;
      $display("FAILED at %0t: pin %0d high %0d cycles in 4 periods, expected %0d",
               $time, p, count, expected);
    end
  endtask

  task automatic tick_then_stop(input int p);
    logic [dw-1:0] word;
    bus_read(reg_addr(p, pinctl_pkg::reg_tick), '0, 1'b0, word);
    if (word >= model[p].period) begin
      value_errors++;
      $display("FAILED at %0t: pin %0d tick 0x%0h not below period 0x%0h",
               $time, p, word, model[p].period);
    end
    write_reg(p, pinctl_pkg::reg_mode, dw'(pinctl_pkg::mode_off));
    @(negedge sys_clk);
    if (pins[p] !== 1'b0) begin
      value_errors++;
      $display("FAILED at %0t: pin %0d not low after mode off", $time, p);
    end
    read_check(reg_addr(p, pinctl_pkg::reg_tick), '0);
  endtask

  initial begin : main
    logic [dw-1:0] period;
    logic [dw-1:0] duty;
    void'($urandom(24275));
    reset       <= 1'b1;
    ebi_cs      <= 1'b1;
    ebi_wr      <= 1'b1;
    ebi_rd      <= 1'b1;
    ebi_addr    <= '0;
    ebi_data_in <= '0;
    for (int p = 0; p < np; p++) begin
      model[p] = '0;
    end
    repeat (3) @(posedge sys_clk);
    reset <= 1'b0;
    @(negedge sys_clk);
    oe_quiet = 1'b1;
    if (pins !== '0 || ebi_data_oe !== 1'b0 || ebi_data_out !== '0) begin
      value_errors++;
      $display("FAILED at %0t: outputs not idle after reset", $time);
    end
    for (int p = 0; p < np; p++) begin
      for (int r = 0; r < pinctl_pkg::words_per_pin; r++) begin
        read_check(reg_addr(p, idx_w'(r)), '0);
      end
    end

    // random configuration and readback
    for (int p = 0; p < np; p++) begin
      write_reg(p, pinctl_pkg::reg_period, dw'($urandom));
      write_reg(p, pinctl_pkg::reg_duty, dw'($urandom));
      write_reg(p, pinctl_pkg::reg_mode, dw'($urandom));
    end
    for (int p = 0; p < np; p++) begin
      for (int r = 0; r < 3; r++) begin
        read_check(reg_addr(p, idx_w'(r)), expected_word(reg_addr(p, idx_w'(r))));
      end
    end
    read_check(aw'(pinctl_pkg::pin_base - 1), expected_word(aw'(pinctl_pkg::pin_base - 1)));
    read_check(reg_addr(np, pinctl_pkg::reg_mode), expected_word(reg_addr(np, 2'd0)));

    // square pins in the lower half and PWM pins in the upper half
    for (int p = 0; p < np / 2; p++) begin
      write_reg(p, pinctl_pkg::reg_period, dw'(2 * $urandom_range(20, 2)));
      write_reg(p, pinctl_pkg::reg_mode, dw'(pinctl_pkg::mode_square));
    end
    for (int p = np / 2; p < np; p++) begin
      period = dw'($urandom_range(40, 4));
      case (p - np / 2)
        0:       duty = '0;
        1:       duty = period;
        2:       duty = period + dw'($urandom_range(100, 1));
        default: duty = dw'($urandom_range(int'(period) - 1, 1));
      endcase
      write_reg(p, pinctl_pkg::reg_period, period);
      write_reg(p, pinctl_pkg::reg_duty, duty);
      write_reg(p, pinctl_pkg::reg_mode, dw'(pinctl_pkg::mode_pwm));
    end
    for (int p = 0; p < np; p++) begin
      measure_pin(p);
    end

    tick_then_stop(0);
    tick_then_stop(np - 1);

    $display("errors: %0d value, %0d output enable", value_errors, oe_errors);
    if (value_errors == 0 && oe_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/pinctl_top.sv
// **************************************************
// top level of the pin controller with one bus
// bridge feeding an array of pin controllers, whose
// read words are gathered back for the bus
// **************************************************

`timescale 1ns/1ns
`default_nettype none

module pinctl_top (
  input  logic                            sys_clk,
  input  logic                            reset,
  input  logic                            ebi_cs,
  input  logic                            ebi_wr,
  input  logic                            ebi_rd,
  input  logic [pinctl_pkg::addr_w-1:0]   ebi_addr,
  input  logic [pinctl_pkg::data_w-1:0]   ebi_data_in,
  output logic [pinctl_pkg::data_w-1:0]   ebi_data_out,
  output logic                            ebi_data_oe,
  output logic [pinctl_pkg::num_pins-1:0] pins
);

  pinctl_pkg::bus_cmd_t cmd;

  // one read slot per pin controller
  logic [pinctl_pkg::num_pins-1:0][pinctl_pkg::data_w-1:0] rd_words;

  ebi_bridge bridge0 (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .ebi_cs       (ebi_cs),
    .ebi_wr       (ebi_wr),
    .ebi_rd       (ebi_rd),
    .ebi_addr     (ebi_addr),
    .ebi_data_in  (ebi_data_in),
    .rd_words     (rd_words),
    .cmd          (cmd),
    .ebi_data_out (ebi_data_out),
    .ebi_data_oe  (ebi_data_oe)
  );

  for (genvar i = 0; i < pinctl_pkg::num_pins; i++) begin : g_pin
    pin_control #(.position(i)) pc (
      .sys_clk (sys_clk),
      .reset   (reset),
      .cmd     (cmd),
      .rd_word (rd_words[i]),
      .pin     (pins[i])
    );
  end

endmodule

`default_nettype wire

//--- logic/pin_control.sv
// **************************************************
// one pin with its four-word register window, tick
// counter and square or PWM level on a registered
// output; position picks the window in the address map
// **************************************************

`timescale 1ns/1ns
`default_nettype none

module pin_control #(
  parameter int position = 0
) (
  input  logic                          sys_clk,
  input  logic                          reset,
  input  pinctl_pkg::bus_cmd_t          cmd,
  output logic [pinctl_pkg::data_w-1:0] rd_word,
  output logic                          pin
);

  localparam int addr_w = pinctl_pkg::addr_w;
  localparam int data_w = pinctl_pkg::data_w;
  localparam int idx_w  = pinctl_pkg::reg_idx_w;

  localparam logic [addr_w-1:0] win_base =
    addr_w'(pinctl_pkg::pin_base + position * pinctl_pkg::words_per_pin);

  pinctl_pkg::pin_cfg_t cfg;

  logic [addr_w-1:0] addr_off;
  logic [idx_w-1:0]  reg_idx;
  logic              hit;
  logic              clr_tick;
  logic              running;
  logic [data_w-1:0] period_eff;
  logic [data_w-1:0] tick;
  logic              level;
  logic [data_w-1:0] rd_sel;

  // below the window the subtraction wraps to a large value
  assign addr_off = cmd.addr - win_base;
  assign hit      = addr_off < addr_w'(pinctl_pkg::words_per_pin);
  assign reg_idx  = addr_off[idx_w-1:0];

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      cfg <= '0;
    end else if (cmd.wr && hit) begin
      case (reg_idx)
        pinctl_pkg::reg_mode:   cfg.mode   <= cmd.data[pinctl_pkg::mode_w-1:0];
        pinctl_pkg::reg_period: cfg.period <= cmd.data;
        pinctl_pkg::reg_duty:   cfg.duty   <= cmd.data;
        default: ;
      endcase
    end
  end

  // a new mode or period restarts the waveform
  assign clr_tick = cmd.wr && hit &&
                    (reg_idx == pinctl_pkg::reg_mode || reg_idx == pinctl_pkg::reg_period);

  assign running = (cfg.mode == pinctl_pkg::mode_square) ||
                   (cfg.mode == pinctl_pkg::mode_pwm);

  // zero period behaves as one
  assign period_eff = (cfg.period == '0) ? data_w'(1) : cfg.period;

  always_ff @(posedge sys_clk) begin
    if (reset || clr_tick || !running) begin
      tick <= '0;
    end else if (tick >= period_eff - 1'b1) begin
      tick <= '0;
    end else begin
      tick <= tick + 1'b1;
    end
  end

  always_comb begin
    case (cfg.mode)
      pinctl_pkg::mode_off:    level = 1'b0;
      pinctl_pkg::mode_square: level = tick < (period_eff >> 1);
      pinctl_pkg::mode_pwm:    level = tick < cfg.duty;
      default:                 level = 1'b0;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      pin <= 1'b0;
    end else begin
      pin <= level;
    end
  end

  always_comb begin
    case (reg_idx)
      pinctl_pkg::reg_mode:   rd_sel = data_w'(cfg.mode);
      pinctl_pkg::reg_period: rd_sel = cfg.period;
      pinctl_pkg::reg_duty:   rd_sel = cfg.duty;
      pinctl_pkg::reg_tick:   rd_sel = tick;
      default:                rd_sel = '0;
    endcase
  end

  // held between reads so the bridge can keep its output
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      rd_word <= '0;
    end else if (cmd.rd) begin
      rd_word <= hit ? rd_sel : '0;
    end
  end

  a_tick_in_period: assert property (@(posedge sys_clk) disable iff (reset)
    (cfg.period != '0) |-> (tick < cfg.period));
  a_off_pin_low: assert property (@(posedge sys_clk) disable iff (reset)
    !running |=> !pin);

endmodule

`default_nettype wire

//--- logic/ebi_bridge.sv
// **************************************************
// external memory bus bridge that synchronizes the
// active-low strobes, issues one-cycle register
// commands and returns the merged read word
// **************************************************

`timescale 1ns/1ns
`default_nettype none

module ebi_bridge (
  input  logic                                                   sys_clk,
  input  logic                                                   reset,
  input  logic                                                   ebi_cs,
  input  logic                                                   ebi_wr,
  input  logic                                                   ebi_rd,
  input  logic [pinctl_pkg::addr_w-1:0]                          ebi_addr,
  input  logic [pinctl_pkg::data_w-1:0]                          ebi_data_in,
  input  logic [pinctl_pkg::num_pins-1:0][pinctl_pkg::data_w-1:0] rd_words,
  output pinctl_pkg::bus_cmd_t                                   cmd,
  output logic [pinctl_pkg::data_w-1:0]                          ebi_data_out,
  output logic                                                   ebi_data_oe
);

  localparam int last = pinctl_pkg::sync_stages - 1;

  // active-high strobes after synchronization
  logic [last:0] cs_sync;
  logic [last:0] wr_sync;
  logic [last:0] rd_sync;

  logic wr_act;
  logic rd_act;
  logic wr_act_q;
  logic rd_act_q;
  logic wr_edge;
  logic rd_edge;

  logic [pinctl_pkg::data_w-1:0] rd_merge;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      cs_sync <= '0;
      wr_sync <= '0;
      rd_sync <= '0;
    end else begin
      cs_sync <= {cs_sync[last-1:0], ~ebi_cs};
      wr_sync <= {wr_sync[last-1:0], ~ebi_wr};
      rd_sync <= {rd_sync[last-1:0], ~ebi_rd};
    end
  end

  assign wr_act = cs_sync[last] & wr_sync[last];
  assign rd_act = cs_sync[last] & rd_sync[last];

  // registered leading edge of each access
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      wr_act_q <= 1'b0;
      rd_act_q <= 1'b0;
      wr_edge  <= 1'b0;
      rd_edge  <= 1'b0;
    end else begin
      wr_act_q <= wr_act;
      rd_act_q <= rd_act;
      wr_edge  <= wr_act & ~wr_act_q;
      rd_edge  <= rd_act & ~rd_act_q;
    end
  end

  // one-cycle pulses carrying the address and data of the edge
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      cmd.wr <= 1'b0;
      cmd.rd <= 1'b0;
    end else begin
      cmd.wr <= wr_edge;
      cmd.rd <= rd_edge;
    end
    if (wr_edge || rd_edge) begin
      cmd.addr <= ebi_addr;
      cmd.data <= ebi_data_in;
    end
  end

  // unaddressed controllers return zero, so OR is a mux
  always_comb begin
    rd_merge = '0;
    for (int i = 0; i < pinctl_pkg::num_pins; i++) begin
      rd_merge = rd_merge | rd_words[i];
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      ebi_data_out <= '0;
    end else begin
      ebi_data_out <= rd_merge;
    end
  end

  assign ebi_data_oe = rd_act;

  a_one_pulse_kind: assert property (@(posedge sys_clk) disable iff (reset)
    !(cmd.wr && cmd.rd));
  a_wr_single: assert property (@(posedge sys_clk) disable iff (reset)
    cmd.wr |=> !cmd.wr);
  a_rd_single: assert property (@(posedge sys_clk) disable iff (reset)
    cmd.rd |=> !cmd.rd);

endmodule

`default_nettype wire

//--- logic/pinctl_pkg.sv
// **************************************************
// shared widths, register map and payload types for
// the bus-mapped pin controller; modules refer to
// these by scoped name
// **************************************************

`default_nettype none

package pinctl_pkg;

  // external bus geometry
  localparam int addr_w = 19;
  localparam int data_w = 16;

  // pin array and its place in the word address map
  localparam int num_pins      = 8;
  localparam int pin_base      = 'h32;
  localparam int words_per_pin = 4;
  localparam int reg_idx_w     = $clog2(words_per_pin);

  // register offsets inside one pin window
  localparam logic [reg_idx_w-1:0] reg_mode   = 2'd0;
  localparam logic [reg_idx_w-1:0] reg_period = 2'd1;
  localparam logic [reg_idx_w-1:0] reg_duty   = 2'd2;
  // running tick counter is read only
  localparam logic [reg_idx_w-1:0] reg_tick   = 2'd3;

  // waveform codes where any other code acts as off
  localparam int mode_w = 2;
  localparam logic [mode_w-1:0] mode_off    = 2'd0;
  localparam logic [mode_w-1:0] mode_square = 2'd1;
  localparam logic [mode_w-1:0] mode_pwm    = 2'd2;

  // depth of the strobe synchronizer
  localparam int sync_stages = 2;

  // one register access with single-cycle pulses
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic              wr;
    logic              rd;
  } bus_cmd_t;

  // writable part of a pin's register window
  typedef struct packed {
    logic [mode_w-1:0] mode;
    logic [data_w-1:0] period;
    logic [data_w-1:0] duty;
  } pin_cfg_t;

endpackage

`default_nettype wire
